// ==== Bender.yml ====
package:
  name: montgomery

export_include_dirs:
  - .

sources:
  - mont_pkg.sv
  - mont_operand_regs.sv
  - mont_multiple_table.sv
  - mont_accumulator.sv
  - mont_controller.sv
  - montgomery_top.sv
  - target: test
    files:
      - tb_montgomery.sv

// ==== mont_accumulator.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mont_defs.svh"

module mont_accumulator (
    input  wire                      clk,
    input  wire                      resetn,
    input  wire mont_pkg::acc_op_e   acc_op,
    input  wire mont_pkg::digit_t    digit,
    input  wire mont_pkg::operands_t operands,
    input  wire mont_pkg::wide_t     entry,
    output mont_pkg::table_idx_t     entry_idx,
    output logic                     sum_negative,
    output mont_pkg::operand_t       result
);

    mont_pkg::wide_t  c_q;
    mont_pkg::wide_t  m_ext;
    mont_pkg::digit_t bd_low;
    mont_pkg::digit_t t_low;
    mont_pkg::digit_t q;

    assign m_ext = mont_pkg::wide_t'(operands.m);

    // Quotient digit makes C + digit*B + q*M divisible by 4
    always_comb begin
        bd_low = digit * operands.b[1:0];
        t_low  = c_q[1:0] + bd_low;
        if (t_low[0]) begin
            q = (operands.m[1] == t_low[1]) ? 2'd3 : 2'd1;
        end else begin
            q = t_low[1] ? 2'd2 : 2'd0;
        end
    end

    assign entry_idx    = '{b_mult: digit, m_mult: q};
    assign sum_negative = c_q[`MONT_WIDTH+`MONT_EXT_BITS-1];

    // C stays below 2M, so C + 3B + 3M fits the guard bits
    always_ff @(posedge clk) begin
        case (acc_op)
            mont_pkg::acc_clear: c_q <= '0;
            mont_pkg::acc_step:  c_q <= (c_q + entry) >> `MONT_DIGIT_BITS;
            mont_pkg::acc_sub_m: c_q <= c_q - m_ext;
            mont_pkg::acc_add_m: c_q <= c_q + m_ext;
            default:             c_q <= c_q;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            result <= '0;
        end else if (acc_op == mont_pkg::acc_store) begin
            result <= c_q[`MONT_WIDTH-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== mont_controller.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mont_defs.svh"

module mont_controller (
    input  wire               clk,
    input  wire               resetn,
    input  wire               start,
    input  wire               table_ready,
    input  wire               sum_negative,
    output logic              capture,
    output logic              shift,
    output logic              table_build,
    output mont_pkg::acc_op_e acc_op,
    output logic              done
);

    localparam int CNT_BITS  = $clog2(`MONT_WIDTH);
    localparam int LAST_STEP = `MONT_WIDTH / `MONT_DIGIT_BITS - 1;

    mont_pkg::mont_state_e state_q;
    mont_pkg::mont_state_e state_d;
    logic [CNT_BITS-1:0]   step_cnt;
    logic                  last_step;

    assign last_step = (step_cnt == CNT_BITS'(LAST_STEP));

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q <= mont_pkg::st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // Counts digit steps, idles at zero outside the loop
    always_ff @(posedge clk) begin
        if (!resetn) begin
            step_cnt <= '0;
        end else if (state_q == mont_pkg::st_iterate) begin
            step_cnt <= step_cnt + 1'b1;
        end else begin
            step_cnt <= '0;
        end
    end

    // Result register is written in st_finish, so done lines up with it
    always_ff @(posedge clk) begin
        if (!resetn) begin
            done <= 1'b0;
        end else begin
            done <= (state_q == mont_pkg::st_finish);
        end
    end

    always_comb begin
        state_d     = state_q;
        capture     = 1'b0;
        shift       = 1'b0;
        table_build = 1'b0;
        acc_op      = mont_pkg::acc_hold;
        case (state_q)
            mont_pkg::st_idle: begin
                if (start) begin
                    capture = 1'b1;
                    state_d = mont_pkg::st_load;
                end
            end
            mont_pkg::st_load: begin
                table_build = 1'b1;
                acc_op      = mont_pkg::acc_clear;
                state_d     = mont_pkg::st_build;
            end
            mont_pkg::st_build: begin
                if (table_ready) begin
                    state_d = mont_pkg::st_iterate;
                end
            end
            mont_pkg::st_iterate: begin
                shift  = 1'b1;
                acc_op = mont_pkg::acc_step;
                if (last_step) begin
                    state_d = mont_pkg::st_reduce_sub;
                end
            end
            mont_pkg::st_reduce_sub: begin
                // Stop subtracting once C has gone below zero
                if (sum_negative) begin
                    state_d = mont_pkg::st_reduce_add;
                end else begin
                    acc_op = mont_pkg::acc_sub_m;
                end
            end
            mont_pkg::st_reduce_add: begin
                acc_op  = mont_pkg::acc_add_m;
                state_d = mont_pkg::st_finish;
            end
            mont_pkg::st_finish: begin
                acc_op  = mont_pkg::acc_store;
                state_d = mont_pkg::st_idle;
            end
            default: begin
                state_d = mont_pkg::st_idle;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== mont_defs.svh ====
`ifndef MONT_DEFS_SVH
`define MONT_DEFS_SVH

// Operand width, must be even
`define MONT_WIDTH 64

// Radix-4 digit
`define MONT_DIGIT_BITS 2

// Headroom for 3B + 3M and the sign during reduction
`define MONT_EXT_BITS 3

`endif

// ==== mont_multiple_table.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mont_defs.svh"

module mont_multiple_table (
    input  wire                       clk,
    input  wire                       resetn,
    input  wire                       table_build,
    input  wire mont_pkg::operands_t  operands,
    input  wire mont_pkg::table_idx_t entry_idx,
    output mont_pkg::wide_t           entry,
    output logic                      table_ready
);

    localparam int BUILD_STEPS = 11;

    // Slot 0 is 3B, slot 1 is 3M, slots 2..10 hold iB + jM for i, j in 1..3
    mont_pkg::wide_t mult_q [0:BUILD_STEPS-1];

    mont_pkg::wide_t     b_ext;
    mont_pkg::wide_t     m_ext;
    mont_pkg::wide_t     build_sum;
    mont_pkg::table_idx_t x_idx;
    mont_pkg::table_idx_t y_idx;
    logic [3:0]          build_cnt;
    logic [3:0]          k;

    assign b_ext = mont_pkg::wide_t'(operands.b);
    assign m_ext = mont_pkg::wide_t'(operands.m);

    function automatic mont_pkg::wide_t select_entry(mont_pkg::table_idx_t idx);
        mont_pkg::wide_t e;
        logic [3:0]      slot;
        slot = 4'd2 + 4'd3 * (4'(idx.b_mult) - 4'd1) + (4'(idx.m_mult) - 4'd1);
        if (idx.b_mult == 2'd0) begin
            case (idx.m_mult)
                2'd0:    e = '0;
                2'd1:    e = m_ext;
                2'd2:    e = m_ext << 1;
                default: e = mult_q[1];
            endcase
        end else if (idx.m_mult == 2'd0) begin
            case (idx.b_mult)
                2'd1:    e = b_ext;
                2'd2:    e = b_ext << 1;
                default: e = mult_q[0];
            endcase
        end else begin
            e = mult_q[slot];
        end
        return e;
    endfunction

    always_comb begin
        entry = select_entry(entry_idx);
    end

    // Build operands, the adder is shared by all steps
    always_comb begin
        k = build_cnt - 4'd3;
        case (build_cnt)
            4'd1: begin
                x_idx = '{b_mult: 2'd2, m_mult: 2'd0};
                y_idx = '{b_mult: 2'd1, m_mult: 2'd0};
            end
            4'd2: begin
                x_idx = '{b_mult: 2'd0, m_mult: 2'd2};
                y_idx = '{b_mult: 2'd0, m_mult: 2'd1};
            end
            default: begin
                x_idx = '{b_mult: mont_pkg::digit_t'(k / 3 + 1), m_mult: 2'd0};
                y_idx = '{b_mult: 2'd0, m_mult: mont_pkg::digit_t'(k % 3 + 1)};
            end
        endcase
        build_sum = select_entry(x_idx) + select_entry(y_idx);
    end

    always_ff @(posedge clk) begin
        if (build_cnt != 4'd0) begin
            mult_q[build_cnt - 4'd1] <= build_sum;
        end
    end

    // Ready goes up while the last entry is written, in time for the first step
    always_ff @(posedge clk) begin
        if (!resetn) begin
            build_cnt   <= '0;
            table_ready <= 1'b0;
        end else if (table_build) begin
            build_cnt   <= 4'd1;
            table_ready <= 1'b0;
        end else if (build_cnt != 4'd0) begin
            build_cnt <= (build_cnt == 4'(BUILD_STEPS)) ? 4'd0 : build_cnt + 4'd1;
            if (build_cnt == 4'(BUILD_STEPS - 1)) begin
                table_ready <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== mont_operand_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mont_defs.svh"

module mont_operand_regs (
    input  wire                     clk,
    input  wire                     resetn,
    input  wire                     capture,
    input  wire                     shift,
    input  wire mont_pkg::operand_t a,
    input  wire mont_pkg::operand_t b,
    input  wire mont_pkg::operand_t m,
    output mont_pkg::operands_t     operands,
    output mont_pkg::digit_t        digit
);

    mont_pkg::operand_t a_q;

    // Multiplicand and modulus stay fixed for the whole operation
    always_ff @(posedge clk) begin
        if (capture) begin
            operands.b <= b;
            operands.m <= m;
        end
    end

    // A is consumed from its low end, one digit per step
    always_ff @(posedge clk) begin
        if (!resetn) begin
            a_q <= '0;
        end else if (capture) begin
            a_q <= a;
        end else if (shift) begin
            a_q <= a_q >> `MONT_DIGIT_BITS;
        end
    end

    assign digit = a_q[`MONT_DIGIT_BITS-1:0];

endmodule

`default_nettype wire

// ==== mont_pkg.sv ====
`default_nettype none

`include "mont_defs.svh"

package mont_pkg;

    typedef logic [`MONT_WIDTH-1:0] operand_t;
    typedef logic [`MONT_WIDTH+`MONT_EXT_BITS-1:0] wide_t;
    typedef logic [`MONT_DIGIT_BITS-1:0] digit_t;

    // Names the table entry b_mult*B + m_mult*M
    typedef struct packed {
        digit_t b_mult;
        digit_t m_mult;
    } table_idx_t;

    typedef struct packed {
        operand_t b;
        operand_t m;
    } operands_t;

    typedef enum logic [2:0] {
        st_idle,
        st_load,
        st_build,
        st_iterate,
        st_reduce_sub,
        st_reduce_add,
        st_finish
    } mont_state_e;

    typedef enum logic [2:0] {
        acc_hold,
        acc_clear,
        acc_step,
        acc_sub_m,
        acc_add_m,
        acc_store
    } acc_op_e;

endpackage

`default_nettype wire

// ==== montgomery_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mont_defs.svh"

module montgomery_top (
    input  wire                     clk,
    input  wire                     resetn,
    input  wire                     start,
    input  wire mont_pkg::operand_t a,
    input  wire mont_pkg::operand_t b,
    input  wire mont_pkg::operand_t m,
    output mont_pkg::operand_t      result,
    output logic                    done
);

    logic                 capture;
    logic                 shift;
    logic                 table_build;
    logic                 table_ready;
    logic                 sum_negative;
    mont_pkg::acc_op_e    acc_op;
    mont_pkg::operands_t  operands;
    mont_pkg::digit_t     digit;
    mont_pkg::table_idx_t entry_idx;
    mont_pkg::wide_t      entry;

    mont_operand_regs i_operand_regs (
        .clk      (clk),
        .resetn   (resetn),
        .capture  (capture),
        .shift    (shift),
        .a        (a),
        .b        (b),
        .m        (m),
        .operands (operands),
        .digit    (digit)
    );

    mont_multiple_table i_multiple_table (
        .clk         (clk),
        .resetn      (resetn),
        .table_build (table_build),
        .operands    (operands),
        .entry_idx   (entry_idx),
        .entry       (entry),
        .table_ready (table_ready)
    );

    mont_accumulator i_accumulator (
        .clk          (clk),
        .resetn       (resetn),
        .acc_op       (acc_op),
        .digit        (digit),
        .operands     (operands),
        .entry        (entry),
        .entry_idx    (entry_idx),
        .sum_negative (sum_negative),
        .result       (result)
    );

    mont_controller i_controller (
        .clk          (clk),
        .resetn       (resetn),
        .start        (start),
        .table_ready  (table_ready),
        .sum_negative (sum_negative),
        .capture      (capture),
        .shift        (shift),
        .table_build  (table_build),
        .acc_op       (acc_op),
        .done         (done)
    );

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
mont_pkg.sv
mont_operand_regs.sv
mont_multiple_table.sv
mont_accumulator.sv
mont_controller.sv
montgomery_top.sv
tb_montgomery.sv

// ==== tb_montgomery.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mont_defs.svh"

module tb_montgomery;

    localparam int N_TABLE        = 10;
    localparam int N_RAND         = 24;
    localparam int N_OPS          = N_TABLE + N_RAND + 2;
    localparam int TIMEOUT_CYCLES = N_OPS * (`MONT_WIDTH / 2 + 32) + 50;

    typedef logic [2*`MONT_WIDTH-1:0] dbl_t;

    typedef struct packed {
        mont_pkg::operand_t a;
        mont_pkg::operand_t b;
        mont_pkg::operand_t m;
        mont_pkg::operand_t exp_r;
        logic               has_exp;
    } vector_t;

    logic               clk;
    logic               resetn;
    logic               start;
    mont_pkg::operand_t a;
    mont_pkg::operand_t b;
    mont_pkg::operand_t m;
    mont_pkg::operand_t result;
    logic               done;

    vector_t            vectors [N_TABLE];
    integer             seed;
    int                 error_count;
    int                 check_count;
    int                 cycle_count;
    int                 done_count;
    logic               monitor_on;
    logic               done_q;
    mont_pkg::operand_t result_q;

    montgomery_top i_dut (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .a      (a),
        .b      (b),
        .m      (m),
        .result (result),
        .done   (done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("checks: %0d, errors: %0d", check_count, error_count + 1);
        $display("TEST FAILED");
        $finish;
    end

    task automatic log_mismatch(input string sig, input mont_pkg::operand_t got,
                                input mont_pkg::operand_t expected);
        error_count++;
        $display("MISMATCH at %0t: %s got %h, expected %h", $time, sig, got, expected);
    endtask

    task automatic log_failure(input string what);
        error_count++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    function automatic dbl_t mod_mul(dbl_t x, dbl_t y, dbl_t n);
        return (x * y) % n;
    endfunction

    // R * 2^W must be congruent to A * B modulo M
    task automatic check_result(input vector_t v, input mont_pkg::operand_t r);
        dbl_t lhs;
        dbl_t rhs;
        lhs = mod_mul(dbl_t'(r), dbl_t'(1) << `MONT_WIDTH, dbl_t'(v.m));
        rhs = mod_mul(dbl_t'(v.a), dbl_t'(v.b), dbl_t'(v.m));
        check_count += 2;
        assert (r < v.m) else
            log_failure($sformatf("result %h is not below the modulus %h", r, v.m));
        assert (lhs == rhs) else
            log_mismatch("result (times 2^W mod m)", lhs[`MONT_WIDTH-1:0],
                         rhs[`MONT_WIDTH-1:0]);
        if (v.has_exp) begin
            check_count++;
            assert (r === v.exp_r) else log_mismatch("result", r, v.exp_r);
        end
    endtask

    task automatic load_vectors();
        mont_pkg::operand_t ones;
        mont_pkg::operand_t msb;
        mont_pkg::operand_t mp;
        ones = '1;
        msb  = mont_pkg::operand_t'(1) << (`MONT_WIDTH - 1);
        mp   = 64'he3a1_55c7_0b2d_9f4b;
        vectors[0] = '{a: '0, b: 64'h0123_4567_89ab_cdef, m: 64'hf123_4567_89ab_cdef,
                       exp_r: '0, has_exp: 1'b1};
        vectors[1] = '{a: 1, b: 1, m: 64'hc3a5_9e17_2b4d_6f81, exp_r: '0, has_exp: 1'b0};
        // 2^W is 1 modulo the all-ones modulus and modulo 3
        vectors[2] = '{a: 1, b: 1, m: ones, exp_r: 1, has_exp: 1'b1};
        vectors[3] = '{a: mp - 1, b: mp - 1, m: mp, exp_r: '0, has_exp: 1'b0};
        vectors[4] = '{a: ones - 1, b: ones - 1, m: ones, exp_r: 1, has_exp: 1'b1};
        vectors[5] = '{a: msb, b: 2, m: ones, exp_r: 1, has_exp: 1'b1};
        vectors[6] = '{a: 2, b: 2, m: 3, exp_r: 1, has_exp: 1'b1};
        vectors[7] = '{a: 1, b: 2, m: 3, exp_r: 2, has_exp: 1'b1};
        vectors[8] = '{a: 64'h8000_0000_0000_0123, b: 64'h7fff_ffff_0000_0001,
                       m: 64'hffff_ffff_ffff_ffc5, exp_r: '0, has_exp: 1'b0};
        vectors[9] = '{a: 64'hdead_beef, b: 64'hcafe_f00d, m: 64'h1_0000_0001,
                       exp_r: '0, has_exp: 1'b0};
    endtask

    task automatic rand_operand(output mont_pkg::operand_t v);
        v = '0;
        for (int i = 0; i < `MONT_WIDTH; i += 32) begin
            v = (v << 32) | mont_pkg::operand_t'($unsigned($random(seed)));
        end
    endtask

    // Starts at the current edge and returns on the edge where done is seen
    task automatic run_op(input vector_t v, input logic poke_busy,
                          output mont_pkg::operand_t r);
        start <= 1'b1;
        a     <= v.a;
        b     <= v.b;
        m     <= v.m;
        @(posedge clk);
        start <= 1'b0;
        if (poke_busy) begin
            repeat (4) @(posedge clk);
            start <= 1'b1;
            a     <= ~v.a;
            b     <= v.b ^ 1;
            m     <= v.m ^ 2;
            @(posedge clk);
            start <= 1'b0;
        end
        @(posedge clk);
        while (done !== 1'b1) @(posedge clk);
        r = result;
    endtask

    // Done is a single pulse and result only moves together with it
    always @(posedge clk) begin
        if (monitor_on) begin
            check_count++;
            assert (!(done && done_q)) else log_failure("done stayed high for two cycles");
            if (!done) begin
                assert (result === result_q) else log_mismatch("result", result, result_q);
            end
        end
        if (done) begin
            done_count <= done_count + 1;
        end
        done_q   <= done;
        result_q <= result;
    end

    initial begin
        vector_t            v;
        mont_pkg::operand_t r;
        int                 snap;
        seed        = 32'h49bad72e;
        error_count = 0;
        check_count = 0;
        done_count  <= 0;
        monitor_on  = 1'b0;
        done_q      <= 1'b0;
        result_q    <= '0;
        resetn      = 1'b0;
        start       = 1'b0;
        a           = '0;
        b           = '0;
        m           = '0;
        load_vectors();
        repeat (8) @(posedge clk);
        resetn <= 1'b1;
        repeat (2) begin
            @(posedge clk);
            check_count += 2;
            assert (done === 1'b0) else log_failure("done is not low after reset");
            assert (result === '0) else log_mismatch("result", result, '0);
        end
        monitor_on = 1'b1;

        // Back to back, so each start lands in the cycle after done
        for (int i = 0; i < N_TABLE; i++) begin
            v   = vectors[i];
            v.a = v.a % v.m;
            v.b = v.b % v.m;
            run_op(v, 1'b0, r);
            check_result(v, r);
        end

        repeat (3) @(posedge clk);
        check_count++;
        assert (done_count == N_TABLE) else
            log_failure($sformatf("saw %0d done pulses for %0d operations",
                                  done_count, N_TABLE));

        // Second start while busy must be dropped
        snap = done_count;
        run_op(vectors[8], 1'b1, r);
        check_result(vectors[8], r);
        repeat (`MONT_WIDTH / 2 + 20) @(posedge clk);
        check_count++;
        assert (done_count == snap + 1) else
            log_failure($sformatf("start while busy gave %0d done pulses instead of one",
                                  done_count - snap));

        for (int i = 0; i < N_RAND; i++) begin
            rand_operand(v.m);
            v.m = v.m | 1;
            rand_operand(v.a);
            v.a = v.a % v.m;
            rand_operand(v.b);
            v.b = v.b % v.m;
            v.exp_r   = '0;
            v.has_exp = 1'b0;
            run_op(v, 1'b0, r);
            check_result(v, r);
        end

        repeat (2) @(posedge clk);
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
